/* src/ace_pkg.sv */
// ACE channel widths, response codes and single-beat channel payload structs
`default_nettype none

package ace_pkg;

  // Bus widths
  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 32;
  localparam int STRB_W     = DATA_W / 8;
  localparam int RESP_W     = 2;
  localparam int AC_SNOOP_W = 4;
  localparam int AC_PROT_W  = 3;
  localparam int CR_RESP_W  = 5;

  // Slave error code on B and R
  localparam logic [RESP_W-1:0] RESP_SLVERR = 2'b10;

  // Read address, single beat so only the address travels
  typedef struct packed {
    logic [ADDR_W-1:0] araddr;
  } ace_ar_t;

  // Read data
  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic [RESP_W-1:0] rresp;
    logic              rlast;
  } ace_r_t;

  // Write address
  typedef struct packed {
    logic [ADDR_W-1:0] awaddr;
  } ace_aw_t;

  // Write data with byte strobes
  typedef struct packed {
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
    logic              wlast;
  } ace_w_t;

  // Write response
  typedef struct packed {
    logic [RESP_W-1:0] bresp;
  } ace_b_t;

  // Snoop address from the interconnect
  typedef struct packed {
    logic [ADDR_W-1:0]     acaddr;
    logic [AC_SNOOP_W-1:0] acsnoop;
    logic [AC_PROT_W-1:0]  acprot;
  } ace_ac_t;

endpackage

`default_nettype wire

/* src/lsu_pkg.sv */
// Load/store opcodes, controller states, pipeline request and response structs
`default_nettype none

package lsu_pkg;

  localparam int XLEN = 32;

  // Bit 3 set for stores, low three bits follow funct3
  typedef enum logic [3:0] {
    OP_LB  = 4'b0000,
    OP_LH  = 4'b0001,
    OP_LW  = 4'b0010,
    OP_LBU = 4'b0100,
    OP_LHU = 4'b0101,
    OP_SB  = 4'b1000,
    OP_SH  = 4'b1001,
    OP_SW  = 4'b1010
  } lsu_op_e;

  typedef enum logic [2:0] {
    IDLE,
    RD_ADDR,
    RD_DATA,
    WR_REQ,
    WR_RESP,
    RESP
  } lsu_state_e;

  // From the pipeline
  typedef struct packed {
    lsu_op_e         op;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
  } lsu_req_t;

  // Back to the pipeline, valid for one cycle
  typedef struct packed {
    logic [XLEN-1:0] rdata;
    logic            err;
    logic            misaligned;
  } lsu_rsp_t;

endpackage

`default_nettype wire

/* src/lsu_align.sv */
// Store lane placement and strobes, load lane extraction and extension, alignment check
`timescale 1ns/100ps
`default_nettype none

module lsu_align (
  input  lsu_pkg::lsu_op_e          op,
  input  logic [1:0]                offset,
  input  logic [lsu_pkg::XLEN-1:0]  store_data,
  input  logic [lsu_pkg::XLEN-1:0]  bus_rdata,
  output logic [lsu_pkg::XLEN-1:0]  wdata,
  output logic [3:0]                wstrb,
  output logic [lsu_pkg::XLEN-1:0]  load_data,
  output logic                      misaligned
);

  logic [7:0]  rd_byte;
  logic [15:0] rd_half;

  // Addressed lanes of the returned word
  assign rd_byte = bus_rdata[{offset, 3'b000} +: 8];
  assign rd_half = bus_rdata[{offset[1], 4'b0000} +: 16];

  // Replicating the low bytes puts them in every lane, strobes pick one
  always_comb begin
    case (op)
      lsu_pkg::OP_SB: begin
        wdata = {4{store_data[7:0]}};
        wstrb = 4'b0001 << offset;
      end
      lsu_pkg::OP_SH: begin
        wdata = {2{store_data[15:0]}};
        wstrb = offset[1] ? 4'b1100 : 4'b0011;
      end
      lsu_pkg::OP_SW: begin
        wdata = store_data;
        wstrb = 4'b1111;
      end
      default: begin
        wdata = store_data;
        wstrb = 4'b0000;
      end
    endcase
  end

  always_comb begin
    case (op)
      lsu_pkg::OP_LB:  load_data = {{24{rd_byte[7]}}, rd_byte};
      lsu_pkg::OP_LBU: load_data = {24'h000000, rd_byte};
      lsu_pkg::OP_LH:  load_data = {{16{rd_half[15]}}, rd_half};
      lsu_pkg::OP_LHU: load_data = {16'h0000, rd_half};
      default:         load_data = bus_rdata;
    endcase
  end

  // Natural alignment, bytes never fault
  always_comb begin
    case (op)
      lsu_pkg::OP_LH, lsu_pkg::OP_LHU, lsu_pkg::OP_SH: misaligned = offset[0];
      lsu_pkg::OP_LW, lsu_pkg::OP_SW:                  misaligned = |offset;
      default:                                         misaligned = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

/* src/lsu_ctrl.sv */
// Load/store transaction FSM driving the ACE read and write channels and the pipeline response
`timescale 1ns/100ps
`default_nettype none

module lsu_ctrl (
  input  logic               clk,
  input  logic               rst,

  // Pipeline side
  input  lsu_pkg::lsu_req_t  req,
  input  logic               req_valid,
  output logic               req_ready,
  output lsu_pkg::lsu_rsp_t  rsp,
  output logic               rsp_valid,

  // Read channels
  output ace_pkg::ace_ar_t   ar,
  output logic               arvalid,
  input  logic               arready,
  input  ace_pkg::ace_r_t    r,
  input  logic               rvalid,
  output logic               rready,

  // Write channels
  output ace_pkg::ace_aw_t   aw,
  output logic               awvalid,
  input  logic               awready,
  output ace_pkg::ace_w_t    w,
  output logic               wvalid,
  input  logic               wready,
  input  ace_pkg::ace_b_t    b,
  input  logic               bvalid,
  output logic               bready,

  output logic               rack,
  output logic               wack
);

  lsu_pkg::lsu_state_e       state;
  lsu_pkg::lsu_op_e          op_q;
  logic [lsu_pkg::XLEN-1:0]  addr_q;
  ace_pkg::ace_w_t           w_q;

  lsu_pkg::lsu_op_e          al_op;
  logic [1:0]                al_offset;
  logic [lsu_pkg::XLEN-1:0]  al_wdata;
  logic [3:0]                al_wstrb;
  logic [lsu_pkg::XLEN-1:0]  al_load_data;
  logic                      al_misaligned;

  logic accept;
  logic aw_fin;
  logic w_fin;
  logic r_done;
  logic b_done;

  assign req_ready = (state == lsu_pkg::IDLE);
  assign accept    = req_valid && req_ready;

  // A channel is finished once its valid has dropped or it transfers now
  assign aw_fin = !awvalid || awready;
  assign w_fin  = !wvalid || wready;
  assign r_done = (state == lsu_pkg::RD_DATA) && rvalid;
  assign b_done = (state == lsu_pkg::WR_RESP) && bvalid;

  // Aligner looks at the incoming request while idle, else the held one
  always_comb begin
    if (state == lsu_pkg::IDLE) begin
      al_op     = req.op;
      al_offset = req.addr[1:0];
    end else begin
      al_op     = op_q;
      al_offset = addr_q[1:0];
    end
  end

  lsu_align u_align (
    .op         (al_op),
    .offset     (al_offset),
    .store_data (req.wdata),
    .bus_rdata  (r.rdata),
    .wdata      (al_wdata),
    .wstrb      (al_wstrb),
    .load_data  (al_load_data),
    .misaligned (al_misaligned)
  );

  // Word-aligned address on both address channels
  assign ar = '{araddr: {addr_q[lsu_pkg::XLEN-1:2], 2'b00}};
  assign aw = '{awaddr: {addr_q[lsu_pkg::XLEN-1:2], 2'b00}};
  assign w  = w_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= lsu_pkg::IDLE;
      arvalid   <= 1'b0;
      awvalid   <= 1'b0;
      wvalid    <= 1'b0;
      rready    <= 1'b0;
      bready    <= 1'b0;
      rsp_valid <= 1'b0;
      rack      <= 1'b0;
      wack      <= 1'b0;
    end else begin
      rsp_valid <= 1'b0;
      rack      <= 1'b0;
      wack      <= 1'b0;
      case (state)
        lsu_pkg::IDLE: begin
          if (accept) begin
            if (al_misaligned) begin
              rsp_valid <= 1'b1;
              state     <= lsu_pkg::RESP;
            end else if (req.op[3]) begin
              awvalid <= 1'b1;
              wvalid  <= 1'b1;
              state   <= lsu_pkg::WR_REQ;
            end else begin
              arvalid <= 1'b1;
              state   <= lsu_pkg::RD_ADDR;
            end
          end
        end
        lsu_pkg::RD_ADDR: begin
          if (arready) begin
            arvalid <= 1'b0;
            rready  <= 1'b1;
            state   <= lsu_pkg::RD_DATA;
          end
        end
        lsu_pkg::RD_DATA: begin
          if (rvalid) begin
            rready    <= 1'b0;
            rsp_valid <= 1'b1;
            rack      <= 1'b1;
            state     <= lsu_pkg::RESP;
          end
        end
        lsu_pkg::WR_REQ: begin
          // AW and W may complete in either order
          if (awready) begin
            awvalid <= 1'b0;
          end
          if (wready) begin
            wvalid <= 1'b0;
          end
          if (aw_fin && w_fin) begin
            bready <= 1'b1;
            state  <= lsu_pkg::WR_RESP;
          end
        end
        lsu_pkg::WR_RESP: begin
          if (bvalid) begin
            bready    <= 1'b0;
            rsp_valid <= 1'b1;
            wack      <= 1'b1;
            state     <= lsu_pkg::RESP;
          end
        end
        default: state <= lsu_pkg::IDLE;
      endcase
    end
  end

  // Held request and response payload
  always_ff @(posedge clk) begin
    if (accept) begin
      op_q   <= req.op;
      addr_q <= req.addr;
      w_q    <= '{wdata: al_wdata, wstrb: al_wstrb, wlast: 1'b1};
    end
    if (accept && al_misaligned) begin
      rsp <= '{rdata: '0, err: 1'b0, misaligned: 1'b1};
    end else if (r_done) begin
      rsp <= '{rdata: al_load_data, err: (r.rresp == ace_pkg::RESP_SLVERR),
               misaligned: 1'b0};
    end else if (b_done) begin
      rsp <= '{rdata: '0, err: (b.bresp == ace_pkg::RESP_SLVERR), misaligned: 1'b0};
    end
  end

  // One transaction at a time on the bus
  a_no_dual_issue: assert property (@(posedge clk) disable iff (rst)
    !(arvalid && awvalid));

  a_ar_hold: assert property (@(posedge clk) disable iff (rst)
    arvalid && !arready |=> arvalid && $stable(ar));

  a_aw_hold: assert property (@(posedge clk) disable iff (rst)
    awvalid && !awready |=> awvalid && $stable(aw));

  a_rsp_pulse: assert property (@(posedge clk) disable iff (rst)
    rsp_valid |=> !rsp_valid);

endmodule

`default_nettype wire

/* src/snoop_resp.sv */
// AC snoop acceptance and registered CR response for a master without a cache
`timescale 1ns/100ps
`default_nettype none

module snoop_resp (
  input  logic                           clk,
  input  logic                           rst,
  input  ace_pkg::ace_ac_t               ac,
  input  logic                           acvalid,
  output logic                           acready,
  output logic [ace_pkg::CR_RESP_W-1:0]  crresp,
  output logic                           crvalid,
  input  logic                           crready
);

  logic pending;

  // Set by a snoop, cleared when its answer is taken
  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= 1'b0;
    end else if (acvalid && acready) begin
      pending <= 1'b1;
    end else if (crvalid && crready) begin
      pending <= 1'b0;
    end
  end

  // Only one snoop in flight
  assign acready = !pending;
  assign crvalid = pending;

  // No data, not shared, not dirty, nothing is ever cached here
  assign crresp = '0;

  a_cr_hold: assert property (@(posedge clk) disable iff (rst)
    crvalid && !crready |=> crvalid);

  // Interconnect must hold a snoop it cannot yet hand over
  a_ac_hold: assert property (@(posedge clk) disable iff (rst)
    acvalid && !acready |=> acvalid && $stable(ac));

endmodule

`default_nettype wire

/* src/lsu_wrap.sv */
// Load/store unit top level with pipeline ports and flat ACE master ports
`timescale 1ns/100ps
`default_nettype none

module lsu_wrap (
  input  logic                           clk,
  input  logic                           rst,

  // Pipeline
  input  lsu_pkg::lsu_req_t              req,
  input  logic                           req_valid,
  output logic                           req_ready,
  output lsu_pkg::lsu_rsp_t              rsp,
  output logic                           rsp_valid,

  // AR and R
  output ace_pkg::ace_ar_t               ar,
  output logic                           arvalid,
  input  logic                           arready,
  input  ace_pkg::ace_r_t                r,
  input  logic                           rvalid,
  output logic                           rready,

  // AW, W and B
  output ace_pkg::ace_aw_t               aw,
  output logic                           awvalid,
  input  logic                           awready,
  output ace_pkg::ace_w_t                w,
  output logic                           wvalid,
  input  logic                           wready,
  input  ace_pkg::ace_b_t                b,
  input  logic                           bvalid,
  output logic                           bready,

  // AC and CR
  input  ace_pkg::ace_ac_t               ac,
  input  logic                           acvalid,
  output logic                           acready,
  output logic [ace_pkg::CR_RESP_W-1:0]  crresp,
  output logic                           crvalid,
  input  logic                           crready,

  output logic                           rack,
  output logic                           wack
);

  lsu_ctrl u_ctrl (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .rsp       (rsp),
    .rsp_valid (rsp_valid),
    .ar        (ar),
    .arvalid   (arvalid),
    .arready   (arready),
    .r         (r),
    .rvalid    (rvalid),
    .rready    (rready),
    .aw        (aw),
    .awvalid   (awvalid),
    .awready   (awready),
    .w         (w),
    .wvalid    (wvalid),
    .wready    (wready),
    .b         (b),
    .bvalid    (bvalid),
    .bready    (bready),
    .rack      (rack),
    .wack      (wack)
  );

  // Snoops are answered independently of loads and stores
  snoop_resp u_snoop (
    .clk     (clk),
    .rst     (rst),
    .ac      (ac),
    .acvalid (acvalid),
    .acready (acready),
    .crresp  (crresp),
    .crvalid (crvalid),
    .crready (crready)
  );

endmodule

`default_nettype wire

/* tests/tb_lsu.sv */
// Testbench for the load/store unit with an ACE slave memory model, snoop source and checks
`timescale 1ns/100ps
`default_nettype none

module tb_lsu;

  localparam int NUM_TESTS       = 6;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * 200;

  logic clk;
  logic rst;

  lsu_pkg::lsu_req_t                req;
  logic                             req_valid;
  logic                             req_ready;
  lsu_pkg::lsu_rsp_t                rsp;
  logic                             rsp_valid;
  ace_pkg::ace_ar_t                 ar;
  logic                             arvalid;
  logic                             arready;
  ace_pkg::ace_r_t                  r;
  logic                             rvalid;
  logic                             rready;
  ace_pkg::ace_aw_t                 aw;
  logic                             awvalid;
  logic                             awready;
  ace_pkg::ace_w_t                  w;
  logic                             wvalid;
  logic                             wready;
  ace_pkg::ace_b_t                  b;
  logic                             bvalid;
  logic                             bready;
  ace_pkg::ace_ac_t                 ac;
  logic                             acvalid;
  logic                             acready;
  logic [ace_pkg::CR_RESP_W-1:0]    crresp;
  logic                             crvalid;
  logic                             crready;
  logic                             rack;
  logic                             wack;

  // Slave memory and the scoreboard copy that predicts it
  logic [31:0] mem [16];
  logic [31:0] sb_mem [16];

  logic [31:0] model_rnd;
  logic [31:0] stim_rnd;
  logic        rd_pend;
  logic [31:0] rd_addr;
  logic        aw_got;
  logic        w_got;
  logic [31:0] wr_addr;
  logic [31:0] wr_data;
  logic [3:0]  wr_strb;
  logic [31:0] nw;
  logic        snoop_on;
  logic        snoop_open;
  int          ac_count;
  int          cr_count;
  int          rack_count;
  int          wack_count;

  logic [31:0] exp_rdata;
  logic        exp_err;
  logic        exp_mis;
  logic        exp_load;
  logic [3:0]  exp_idx;
  logic        mis_now;

  int errors    = 0;
  int tests_run = 0;
  int passed    = 0;
  int start;

  lsu_wrap UUT (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] fill_word(input logic [3:0] idx);
    return 32'h9e3779b9 * {28'd0, idx} ^ {4{4'h5, idx}};
  endfunction

  function automatic logic is_store(input lsu_pkg::lsu_op_e op);
    return op == lsu_pkg::OP_SB || op == lsu_pkg::OP_SH || op == lsu_pkg::OP_SW;
  endfunction

  // Halfwords need an even offset and words offset zero
  function automatic logic misaligned_rule(input lsu_pkg::lsu_op_e op, input logic [1:0] off);
    case (op)
      lsu_pkg::OP_LH, lsu_pkg::OP_LHU, lsu_pkg::OP_SH: return off == 2'd1 || off == 2'd3;
      lsu_pkg::OP_LW, lsu_pkg::OP_SW:                  return off != 2'd0;
      default:                                         return 1'b0;
    endcase
  endfunction

  function automatic logic [31:0] load_rule(input lsu_pkg::lsu_op_e op, input logic [31:0] word,
                                            input logic [1:0] off);
    logic [31:0] sh;
    sh = word >> {off, 3'b000};
    case (op)
      lsu_pkg::OP_LB:  return {{24{sh[7]}}, sh[7:0]};
      lsu_pkg::OP_LBU: return {24'd0, sh[7:0]};
      lsu_pkg::OP_LH:  return {{16{sh[15]}}, sh[15:0]};
      lsu_pkg::OP_LHU: return {16'd0, sh[15:0]};
      default:         return word;
    endcase
  endfunction

  function automatic logic [31:0] merge_store(input logic [31:0] old, input lsu_pkg::lsu_op_e op,
                                              input logic [1:0] off, input logic [31:0] data);
    logic [31:0] res;
    int          nbytes;
    res = old;
    case (op)
      lsu_pkg::OP_SB: nbytes = 1;
      lsu_pkg::OP_SH: nbytes = 2;
      default:        nbytes = 4;
    endcase
    for (int k = 0; k < nbytes; k++) begin
      res[8*(off+k) +: 8] = data[8*k +: 8];
    end
    return res;
  endfunction

  function automatic lsu_pkg::lsu_op_e pick_op(input logic [2:0] k);
    case (k)
      3'd0:    return lsu_pkg::OP_LB;
      3'd1:    return lsu_pkg::OP_LH;
      3'd2:    return lsu_pkg::OP_LW;
      3'd3:    return lsu_pkg::OP_LBU;
      3'd4:    return lsu_pkg::OP_LHU;
      3'd5:    return lsu_pkg::OP_SB;
      3'd6:    return lsu_pkg::OP_SH;
      default: return lsu_pkg::OP_SW;
    endcase
  endfunction

  task automatic value_error(input string name, input logic [31:0] got, input logic [31:0] want);
    errors++;
    $display("ERROR %s got 0x%08h expected 0x%08h at %0t", name, got, want, $time);
  endtask

  task automatic event_error(input string what);
    errors++;
    $display("%s at %0t", what, $time);
  endtask

  task automatic test_done(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      passed++;
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: %0d error(s)", name, errors - errors_before);
    end
  endtask

  // One request that returns in the cycle carrying rsp_valid
  task automatic access(input lsu_pkg::lsu_op_e op, input logic [31:0] addr,
                        input logic [31:0] data);
    req       <= '{op: op, addr: addr, wdata: data};
    req_valid <= 1'b1;
    do @(posedge clk); while (!req_ready);
    req_valid <= 1'b0;
    do @(posedge clk); while (!rsp_valid);
  endtask

  assign mis_now = misaligned_rule(req.op, req.addr[1:0]);

  // ACE slave with random ready and valid timing and a snoop source
  initial begin
    arready    = 1'b0;
    r          = '0;
    rvalid     = 1'b0;
    awready    = 1'b0;
    wready     = 1'b0;
    b          = '0;
    bvalid     = 1'b0;
    ac         = '0;
    acvalid    = 1'b0;
    crready    = 1'b0;
    rd_pend    = 1'b0;
    aw_got     = 1'b0;
    w_got      = 1'b0;
    snoop_open = 1'b0;
    ac_count   = 0;
    cr_count   = 0;
    rack_count = 0;
    wack_count = 0;
    model_rnd  = 32'headf;
    for (int i = 0; i < 16; i++) begin
      mem[i[3:0]] = fill_word(i[3:0]);
    end
    forever begin
      @(posedge clk);
      model_rnd = lcg(model_rnd);
      arready <= model_rnd[31];
      awready <= model_rnd[30];
      wready  <= model_rnd[29];
      crready <= model_rnd[28];
      if (arvalid && arready) begin
        rd_pend <= 1'b1;
        rd_addr <= ar.araddr;
      end
      if (rvalid && rready) begin
        rvalid <= 1'b0;
      end else if (rd_pend && !rvalid && model_rnd[27]) begin
        rvalid  <= 1'b1;
        rd_pend <= 1'b0;
        if (rd_addr[31]) begin
          r <= '{rdata: 32'd0, rresp: ace_pkg::RESP_SLVERR, rlast: 1'b1};
        end else begin
          r <= '{rdata: mem[rd_addr[5:2]], rresp: 2'b00, rlast: 1'b1};
        end
      end
      if (awvalid && awready) begin
        aw_got  <= 1'b1;
        wr_addr <= aw.awaddr;
      end
      if (wvalid && wready) begin
        w_got   <= 1'b1;
        wr_data <= w.wdata;
        wr_strb <= w.wstrb;
      end
      if (bvalid && bready) begin
        bvalid <= 1'b0;
      end else if (aw_got && w_got && !bvalid && model_rnd[26]) begin
        aw_got <= 1'b0;
        w_got  <= 1'b0;
        bvalid <= 1'b1;
        if (wr_addr[31]) begin
          b <= '{bresp: ace_pkg::RESP_SLVERR};
        end else begin
          b  <= '{bresp: 2'b00};
          nw = mem[wr_addr[5:2]];
          for (int k = 0; k < 4; k++) begin
            if (wr_strb[k]) nw[8*k +: 8] = wr_data[8*k +: 8];
          end
          mem[wr_addr[5:2]] <= nw;
        end
      end
      if (acvalid && acready) begin
        acvalid    <= 1'b0;
        snoop_open <= 1'b1;
        ac_count   <= ac_count + 1;
      end else if (!acvalid && snoop_on && model_rnd[25:23] == 3'd0) begin
        acvalid <= 1'b1;
        ac      <= '{acaddr: model_rnd, acsnoop: model_rnd[22:19], acprot: model_rnd[18:16]};
      end
      if (crvalid && crready) begin
        snoop_open <= 1'b0;
        cr_count   <= cr_count + 1;
      end
      if (rack) rack_count <= rack_count + 1;
      if (wack) wack_count <= wack_count + 1;
    end
  end

  // Scoreboard predicts each response when its request is accepted
  initial begin
    for (int i = 0; i < 16; i++) begin
      sb_mem[i[3:0]] = fill_word(i[3:0]);
    end
    exp_rdata = 32'd0;
    exp_err   = 1'b0;
    exp_mis   = 1'b0;
    exp_load  = 1'b0;
    exp_idx   = 4'd0;
    forever begin
      @(posedge clk);
      if (req_valid && req_ready) begin
        exp_idx   <= req.addr[5:2];
        exp_mis   <= mis_now;
        exp_err   <= !mis_now && req.addr[31];
        exp_load  <= !is_store(req.op);
        exp_rdata <= load_rule(req.op, sb_mem[req.addr[5:2]], req.addr[1:0]);
        if (is_store(req.op) && !mis_now && !req.addr[31]) begin
          sb_mem[req.addr[5:2]] <= merge_store(sb_mem[req.addr[5:2]], req.op,
                                               req.addr[1:0], req.wdata);
        end
      end
    end
  end

  a_rsp_rdata: assert property (@(posedge clk) disable iff (rst)
    rsp_valid && exp_load && !exp_err && !exp_mis |-> rsp.rdata == exp_rdata)
    else value_error("rsp.rdata", $sampled(rsp.rdata), $sampled(exp_rdata));

  a_rsp_err: assert property (@(posedge clk) disable iff (rst)
    rsp_valid |-> rsp.err == exp_err)
    else value_error("rsp.err", 32'($sampled(rsp.err)), 32'($sampled(exp_err)));

  a_rsp_mis: assert property (@(posedge clk) disable iff (rst)
    rsp_valid |-> rsp.misaligned == exp_mis)
    else value_error("rsp.misaligned", 32'($sampled(rsp.misaligned)), 32'($sampled(exp_mis)));

  // Stores touch only their lanes and error stores nothing
  a_mem_match: assert property (@(posedge clk) disable iff (rst)
    rsp_valid && !exp_load |-> mem[exp_idx] == sb_mem[exp_idx])
    else value_error("mem", $sampled(mem[exp_idx]), $sampled(sb_mem[exp_idx]));

  // Every write is a single beat
  a_wlast: assert property (@(posedge clk) disable iff (rst)
    wvalid |-> w.wlast)
    else event_error("W beat without wlast on a single-beat write");

  a_mis_quiet: assert property (@(posedge clk) disable iff (rst)
    req_valid && req_ready && mis_now |=> rsp_valid && !arvalid && !awvalid)
    else event_error("Misaligned request did not answer at once without bus traffic");

  a_cr_zero: assert property (@(posedge clk) disable iff (rst)
    crvalid |-> crresp == '0)
    else value_error("crresp", 32'($sampled(crresp)), 32'd0);

  a_ac_blocked: assert property (@(posedge clk) disable iff (rst)
    snoop_open |-> !acready)
    else event_error("acready was high while a snoop waited for its CR");

  a_cr_matched: assert property (@(posedge clk) disable iff (rst)
    crvalid && crready |-> snoop_open)
    else event_error("CR transfer without an open snoop");

  a_ac_answer: assert property (@(posedge clk) disable iff (rst)
    acvalid && acready |=> crvalid)
    else event_error("crvalid did not follow an AC transfer");

  a_rack_after_r: assert property (@(posedge clk) disable iff (rst)
    rvalid && rready |=> rack && rsp_valid)
    else event_error("rack with rsp_valid missing after an R transfer");

  a_rack_only: assert property (@(posedge clk) disable iff (rst)
    rack |-> $past(rvalid && rready))
    else event_error("rack high without an R transfer the cycle before");

  a_wack_after_b: assert property (@(posedge clk) disable iff (rst)
    bvalid && bready |=> wack && rsp_valid)
    else event_error("wack with rsp_valid missing after a B transfer");

  a_wack_only: assert property (@(posedge clk) disable iff (rst)
    wack |-> $past(bvalid && bready))
    else event_error("wack high without a B transfer the cycle before");

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Run stopped by the watchdog after %0d cycles", WATCHDOG_CYCLES);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    req       = '0;
    req_valid = 1'b0;
    rst       = 1'b1;
    snoop_on  = 1'b0;
    stim_rnd  = lcg(32'headf);
    repeat (16) @(posedge clk);
    rst      <= 1'b0;
    snoop_on <= 1'b1;
    @(posedge clk);

    start = errors;
    for (int i = 0; i < 6; i++) begin
      stim_rnd = lcg(stim_rnd);
      access(lsu_pkg::OP_SW, {26'd0, i[3:0], 2'b00}, stim_rnd);
      access(lsu_pkg::OP_LW, {26'd0, i[3:0], 2'b00}, 32'd0);
    end
    test_done("word store and load", start);

    start = errors;
    for (int k = 0; k < 4; k++) begin
      stim_rnd = lcg(stim_rnd);
      access(lsu_pkg::OP_SB, {26'd0, 4'd8, k[1:0]}, stim_rnd);
    end
    for (int k = 0; k < 4; k += 2) begin
      stim_rnd = lcg(stim_rnd);
      access(lsu_pkg::OP_SH, {26'd0, 4'd9, k[1:0]}, stim_rnd);
    end
    for (int k = 0; k < 4; k++) begin
      access(lsu_pkg::OP_LB, {26'd0, 4'd8, k[1:0]}, 32'd0);
      access(lsu_pkg::OP_LBU, {26'd0, 4'd8, k[1:0]}, 32'd0);
    end
    for (int k = 0; k < 4; k += 2) begin
      access(lsu_pkg::OP_LH, {26'd0, 4'd9, k[1:0]}, 32'd0);
      access(lsu_pkg::OP_LHU, {26'd0, 4'd9, k[1:0]}, 32'd0);
    end
    test_done("byte and halfword lanes", start);

    start = errors;
    access(lsu_pkg::OP_LH, 32'h0000_0029, 32'd0);
    access(lsu_pkg::OP_LHU, 32'h0000_002b, 32'd0);
    access(lsu_pkg::OP_LW, 32'h0000_002a, 32'd0);
    access(lsu_pkg::OP_SH, 32'h0000_0029, 32'h1234_5678);
    access(lsu_pkg::OP_SW, 32'h0000_002b, 32'h8765_4321);
    test_done("misaligned requests", start);

    start = errors;
    access(lsu_pkg::OP_SW, 32'h8000_0010, 32'hdead_beef);
    access(lsu_pkg::OP_SB, 32'h8000_0011, 32'h0000_00a5);
    access(lsu_pkg::OP_LW, 32'h8000_0010, 32'd0);
    access(lsu_pkg::OP_LW, 32'h0000_0010, 32'd0);
    test_done("slave error", start);

    // Snoops keep arriving while mixed traffic runs
    start = errors;
    for (int i = 0; i < 16; i++) begin
      stim_rnd = lcg(stim_rnd);
      access(pick_op(stim_rnd[31:29]), {stim_rnd[15] & stim_rnd[14], 25'd0, stim_rnd[21:16]},
             lcg(stim_rnd));
    end
    snoop_on <= 1'b0;
    do @(posedge clk); while (acvalid || snoop_open);
    assert (ac_count > 0 && ac_count == cr_count)
      else event_error($sformatf("Snoops %0d and CR responses %0d do not pair up",
                                 ac_count, cr_count));
    test_done("snoop responses", start);

    start = errors;
    assert (rack_count > 0 && wack_count > 0)
      else event_error("No rack or no wack seen during the run");
    test_done("rack and wack", start);

    $display("%0d tests run, %0d passed, %0d errors", tests_run, passed, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
src/ace_pkg.sv
src/lsu_pkg.sv
src/lsu_align.sv
src/lsu_ctrl.sv
src/snoop_resp.sv
src/lsu_wrap.sv
tests/tb_lsu.sv

/* Makefile */
SOURCES := $(wildcard src/*.sv tests/*.sv)

obj_dir/Vtb_lsu: vlog.f $(SOURCES)
	verilator --binary --assert --timing --top-module tb_lsu -f vlog.f

run: obj_dir/Vtb_lsu
	@out="$$(./obj_dir/Vtb_lsu)"; echo "$$out"; echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf obj_dir

.PHONY: run clean
